/* verilog/rv_fe_pkg.sv */
`default_nettype none

package rv_fe_pkg;

  // Address width
  localparam int XLEN = 32;

  // First PC issued out of reset
  localparam logic [XLEN-1:0] RESET_PC = 32'h0000_1000;

  // Fixed instruction size, no compressed support
  localparam logic [XLEN-1:0] INSN_BYTES = 32'd4;

  // PC source chosen by the arbiter
  typedef enum logic [1:0] {
    PC_SEL_SEQ      = 2'd0,
    PC_SEL_PRED     = 2'd1,
    PC_SEL_REDIRECT = 2'd2
  } pc_sel_e;

  // Issued PC and its computed successor
  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] pc_next;
  } pc_pair_t;

  // Prediction metadata that rides along with each PC
  typedef struct packed {
    logic            redir_pending;
    logic            btb_hit;
    logic            btb_taken;
    logic            btb_is_return;
    logic            ras_valid;
    logic [XLEN-1:0] btb_tgt;
    logic [XLEN-1:0] ras_tgt;
  } pred_meta_t;

endpackage

`default_nettype wire

/* verilog/rv_pc_sel_if.sv */
`timescale 1ns/100ps
`default_nettype none

// Arbiter decision, all combinational
interface rv_pc_sel_if;

  // Which source feeds the next PC
  rv_fe_pkg::pc_sel_e sel;

  // Misprediction target from execute
  logic [rv_fe_pkg::XLEN-1:0] redir_tgt;

  // Target of whichever prediction won
  logic [rv_fe_pkg::XLEN-1:0] pred_tgt;

  // Prediction came from BTB or RAS, not decode
  logic early_pred;

  modport arb (
    output sel,
    output redir_tgt,
    output pred_tgt,
    output early_pred
  );

  modport stage (
    input sel,
    input redir_tgt,
    input pred_tgt,
    input early_pred
  );

endinterface

`default_nettype wire

/* verilog/rv_pipe_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

// Valid tracking for a source stage that always has data
module rv_pipe_ctrl (
  input  logic clk,
  input  logic rst_n,
  input  logic ready_i,
  output logic valid_o,
  output logic advance_o
);

  logic valid_q;

  // Register is free when empty or being drained this cycle
  assign advance_o = !valid_q || ready_i;

  // Source never runs dry so valid only drops on reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (advance_o) begin
      valid_q <= 1'b1;
    end
  end

  assign valid_o = valid_q;

endmodule

`default_nettype wire

/* verilog/rv_pipe_reg.sv */
`timescale 1ns/100ps
`default_nettype none

// One-deep pipeline register, payload type set per instance
module rv_pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     advance_i,
  input  payload_t data_i,
  output payload_t data_o
);

  payload_t data_q;

  // Load on advance, otherwise hold for back-pressure
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      data_q <= '0;
    end else if (advance_i) begin
      data_q <= data_i;
    end
  end

  assign data_o = data_q;

endmodule

`default_nettype wire

/* verilog/rv_pc_arb.sv */
`timescale 1ns/100ps
`default_nettype none

// Ranks the PC sources for the next fetch
module rv_pc_arb (
  input  logic                       redirect_i,
  input  logic [rv_fe_pkg::XLEN-1:0] redirect_tgt_i,
  input  logic                       late_pred_i,
  input  logic [rv_fe_pkg::XLEN-1:0] late_pred_tgt_i,
  input  logic                       btb_hit_i,
  input  logic                       btb_taken_i,
  input  logic [rv_fe_pkg::XLEN-1:0] btb_tgt_i,
  input  logic                       btb_is_return_i,
  input  logic                       ras_valid_i,
  input  logic [rv_fe_pkg::XLEN-1:0] ras_tgt_i,
  rv_pc_sel_if.arb                   sel
);

  logic ras_hit;
  logic btb_taken_hit;

  // Return instruction with a usable RAS entry
  assign ras_hit = btb_hit_i && btb_is_return_i && ras_valid_i;

  // Ordinary taken branch out of the BTB
  assign btb_taken_hit = btb_hit_i && btb_taken_i;

  // Redirect target passes through untouched and the stage picks it by sel
  assign sel.redir_tgt = redirect_tgt_i;

  always_comb begin
    sel.sel        = rv_fe_pkg::PC_SEL_SEQ;
    sel.pred_tgt   = late_pred_tgt_i;
    sel.early_pred = 1'b0;

    if (redirect_i) begin
      // Execute overrides every prediction
      sel.sel = rv_fe_pkg::PC_SEL_REDIRECT;
    end else if (late_pred_i) begin
      // Decode caught it after the sequential fetch went out
      sel.sel = rv_fe_pkg::PC_SEL_PRED;
    end else if (ras_hit) begin
      sel.sel        = rv_fe_pkg::PC_SEL_PRED;
      sel.pred_tgt   = ras_tgt_i;
      sel.early_pred = 1'b1;
    end else if (btb_taken_hit) begin
      sel.sel        = rv_fe_pkg::PC_SEL_PRED;
      sel.pred_tgt   = btb_tgt_i;
      sel.early_pred = 1'b1;
    end
  end

endmodule

`default_nettype wire

/* verilog/rv_stage_pc.sv */
`timescale 1ns/100ps
`default_nettype none

// PC register and registered issue to fetch
module rv_stage_pc (
  input  logic                       clk,
  input  logic                       rst_n,
  rv_pc_sel_if.stage                 sel,
  input  logic                       btb_hit_i,
  input  logic                       btb_taken_i,
  input  logic [rv_fe_pkg::XLEN-1:0] btb_tgt_i,
  input  logic                       btb_is_return_i,
  input  logic                       ras_valid_i,
  input  logic [rv_fe_pkg::XLEN-1:0] ras_tgt_i,
  input  logic                       ready_i,
  output logic                       valid_o,
  output logic [rv_fe_pkg::XLEN-1:0] pc_lookup_o,
  output rv_fe_pkg::pc_pair_t        pcs_o,
  output rv_fe_pkg::pred_meta_t      meta_o
);

  logic [rv_fe_pkg::XLEN-1:0] pc_q;
  logic [rv_fe_pkg::XLEN-1:0] pc_next;
  logic                       advance;
  logic                       redir_pending;
  rv_fe_pkg::pc_pair_t        pcs_d;
  rv_fe_pkg::pred_meta_t      meta_d;

  // Next PC from the arbiter's choice
  always_comb begin
    case (sel.sel)
      rv_fe_pkg::PC_SEL_REDIRECT: pc_next = sel.redir_tgt;
      rv_fe_pkg::PC_SEL_PRED:     pc_next = sel.pred_tgt;
      default:                    pc_next = pc_q + rv_fe_pkg::INSN_BYTES;
    endcase
  end

  // PC moves only when the output register takes the current one
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc_q <= rv_fe_pkg::RESET_PC;
    end else if (advance) begin
      pc_q <= pc_next;
    end
  end

  // Raw PC goes straight out for the BTB and RAS lookup
  assign pc_lookup_o = pc_q;

  // Redirects and decode predictions leave a wrong-path fetch behind
  // BTB and RAS hits redirect before the sequential fetch happens
  assign redir_pending = (sel.sel == rv_fe_pkg::PC_SEL_REDIRECT) ||
                         (sel.sel == rv_fe_pkg::PC_SEL_PRED && !sel.early_pred);

  // Output register contents
  always_comb begin
    pcs_d.pc             = pc_q;
    pcs_d.pc_next        = pc_next;
    meta_d.redir_pending = redir_pending;
    meta_d.btb_hit       = btb_hit_i;
    meta_d.btb_taken     = btb_taken_i;
    meta_d.btb_is_return = btb_is_return_i;
    meta_d.ras_valid     = ras_valid_i;
    meta_d.btb_tgt       = btb_tgt_i;
    meta_d.ras_tgt       = ras_tgt_i;
  end

  // Handshake with fetch
  rv_pipe_ctrl u_pipe_ctrl (
    .clk      (clk),
    .rst_n    (rst_n),
    .ready_i  (ready_i),
    .valid_o  (valid_o),
    .advance_o(advance)
  );

  // PC pair register
  rv_pipe_reg #(
    .payload_t(rv_fe_pkg::pc_pair_t)
  ) u_pcs_reg (
    .clk      (clk),
    .rst_n    (rst_n),
    .advance_i(advance),
    .data_i   (pcs_d),
    .data_o   (pcs_o)
  );

  // Metadata register, same enable keeps it aligned with its PC
  rv_pipe_reg #(
    .payload_t(rv_fe_pkg::pred_meta_t)
  ) u_meta_reg (
    .clk      (clk),
    .rst_n    (rst_n),
    .advance_i(advance),
    .data_i   (meta_d),
    .data_o   (meta_o)
  );

  // Stalled entry must not change under fetch
  a_pcs_stable : assert property (
    @(posedge clk) disable iff (!rst_n)
    valid_o && !ready_i |=> $stable(pcs_o)
  );

  a_meta_stable : assert property (
    @(posedge clk) disable iff (!rst_n)
    valid_o && !ready_i |=> $stable(meta_o)
  );

endmodule

`default_nettype wire

/* verilog/rv_fetch_front.sv */
`timescale 1ns/100ps
`default_nettype none

// Fetch front end, arbiter plus PC stage
module rv_fetch_front (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       redirect_i,
  input  logic [rv_fe_pkg::XLEN-1:0] redirect_tgt_i,
  input  logic                       late_pred_i,
  input  logic [rv_fe_pkg::XLEN-1:0] late_pred_tgt_i,
  input  logic                       btb_hit_i,
  input  logic                       btb_taken_i,
  input  logic [rv_fe_pkg::XLEN-1:0] btb_tgt_i,
  input  logic                       btb_is_return_i,
  input  logic                       ras_valid_i,
  input  logic [rv_fe_pkg::XLEN-1:0] ras_tgt_i,
  input  logic                       ready_i,
  output logic                       valid_o,
  output logic [rv_fe_pkg::XLEN-1:0] pc_lookup_o,
  output logic [rv_fe_pkg::XLEN-1:0] pc_o,
  output logic [rv_fe_pkg::XLEN-1:0] pc_next_o,
  output logic                       btb_hit_o,
  output logic                       btb_taken_o,
  output logic [rv_fe_pkg::XLEN-1:0] btb_tgt_o,
  output logic                       btb_is_return_o,
  output logic                       ras_valid_o,
  output logic [rv_fe_pkg::XLEN-1:0] ras_tgt_o,
  output logic                       redir_pending_o
);

  rv_fe_pkg::pc_pair_t   pcs;
  rv_fe_pkg::pred_meta_t meta;

  // Arbiter to stage, same cycle
  rv_pc_sel_if u_sel_if ();

  rv_pc_arb u_pc_arb (
    .redirect_i     (redirect_i),
    .redirect_tgt_i (redirect_tgt_i),
    .late_pred_i    (late_pred_i),
    .late_pred_tgt_i(late_pred_tgt_i),
    .btb_hit_i      (btb_hit_i),
    .btb_taken_i    (btb_taken_i),
    .btb_tgt_i      (btb_tgt_i),
    .btb_is_return_i(btb_is_return_i),
    .ras_valid_i    (ras_valid_i),
    .ras_tgt_i      (ras_tgt_i),
    .sel            (u_sel_if.arb)
  );

  rv_stage_pc u_stage_pc (
    .clk            (clk),
    .rst_n          (rst_n),
    .sel            (u_sel_if.stage),
    .btb_hit_i      (btb_hit_i),
    .btb_taken_i    (btb_taken_i),
    .btb_tgt_i      (btb_tgt_i),
    .btb_is_return_i(btb_is_return_i),
    .ras_valid_i    (ras_valid_i),
    .ras_tgt_i      (ras_tgt_i),
    .ready_i        (ready_i),
    .valid_o        (valid_o),
    .pc_lookup_o    (pc_lookup_o),
    .pcs_o          (pcs),
    .meta_o         (meta)
  );

  // Flatten registered structs onto plain ports
  assign pc_o            = pcs.pc;
  assign pc_next_o       = pcs.pc_next;
  assign redir_pending_o = meta.redir_pending;
  assign btb_hit_o       = meta.btb_hit;
  assign btb_taken_o     = meta.btb_taken;
  assign btb_is_return_o = meta.btb_is_return;
  assign ras_valid_o     = meta.ras_valid;
  assign btb_tgt_o       = meta.btb_tgt;
  assign ras_tgt_o       = meta.ras_tgt;

endmodule

`default_nettype wire

/* verification/rv_fetch_front_tb.sv */
`timescale 1ns/100ps
`default_nettype none

// Directed testbench for the fetch front end acting as the fetch stage
module rv_fetch_front_tb;

  localparam int W            = rv_fe_pkg::XLEN;
  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 4;
  // Watchdog is sized from the transfers planned over all tests
  localparam int TOTAL_XFERS  = 46;
  localparam int WATCHDOG_NS  = (TOTAL_XFERS * 20 + RESET_CYCLES) * CLK_PERIOD;

  logic         clk = 1'b0;
  logic         rst_n;
  logic         redirect_i;
  logic         late_pred_i;
  logic         btb_hit_i;
  logic         btb_taken_i;
  logic         btb_is_return_i;
  logic         ras_valid_i;
  logic         ready_i;
  logic [W-1:0] redirect_tgt_i;
  logic [W-1:0] late_pred_tgt_i;
  logic [W-1:0] btb_tgt_i;
  logic [W-1:0] ras_tgt_i;
  logic         valid_o;
  logic         btb_hit_o;
  logic         btb_taken_o;
  logic         btb_is_return_o;
  logic         ras_valid_o;
  logic         redir_pending_o;
  logic [W-1:0] pc_lookup_o;
  logic [W-1:0] pc_o;
  logic [W-1:0] pc_next_o;
  logic [W-1:0] btb_tgt_o;
  logic [W-1:0] ras_tgt_o;

  // Reference model of the PC register and the output register
  logic                  model_valid;
  logic [W-1:0]          model_pc;
  rv_fe_pkg::pc_pair_t   exp_pcs;
  rv_fe_pkg::pred_meta_t exp_meta;
  // pc_next of the last accepted entry for the chain check
  logic [W-1:0]          last_next;
  logic                  have_last;
  int                    xfer_count = 0;
  int                    errors = 0;
  int                    checks = 0;
  string                 cur_test = "reset";

  always #(CLK_PERIOD / 2) clk = ~clk;

  rv_fetch_front u_rv_fetch_front (.*);

  task automatic check(input string what, input logic [W-1:0] expected,
                       input logic [W-1:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("** Error %s: %s expected %h, actual %h", cur_test, what, expected, actual);
    end
  endtask

  // Sampled at the rising edge after inputs settled on the falling edge
  always @(posedge clk) begin : monitor
    logic [W-1:0] nxt;
    logic         pend;
    if (!rst_n) begin
      model_valid = 1'b0;
      model_pc    = rv_fe_pkg::RESET_PC;
      have_last   = 1'b0;
    end else begin
      check("valid", W'(model_valid), W'(valid_o));
      check("pc_lookup", model_pc, pc_lookup_o);
      // Held entry must match on stalled cycles as well as on transfers
      if (model_valid) begin
        check("pc", exp_pcs.pc, pc_o);
        check("pc_next", exp_pcs.pc_next, pc_next_o);
        check("flags", W'({exp_meta.redir_pending, exp_meta.btb_hit, exp_meta.btb_taken,
                           exp_meta.btb_is_return, exp_meta.ras_valid}),
              W'({redir_pending_o, btb_hit_o, btb_taken_o, btb_is_return_o, ras_valid_o}));
        check("btb_tgt", exp_meta.btb_tgt, btb_tgt_o);
        check("ras_tgt", exp_meta.ras_tgt, ras_tgt_o);
        if (ready_i) begin
          // No skipped or repeated PC between transfers
          if (have_last) begin
            check("pc_chain", last_next, pc_o);
          end
          last_next  = exp_pcs.pc_next;
          have_last  = 1'b1;
          xfer_count++;
        end
      end
      // Output register reloads when empty or drained
      if (!model_valid || ready_i) begin
        pend = 1'b0;
        if (redirect_i) begin
          nxt  = redirect_tgt_i;
          pend = 1'b1;
        end else if (late_pred_i) begin
          nxt  = late_pred_tgt_i;
          pend = 1'b1;
        end else if (btb_hit_i && btb_is_return_i && ras_valid_i) begin
          nxt = ras_tgt_i;
        end else if (btb_hit_i && btb_taken_i) begin
          nxt = btb_tgt_i;
        end else begin
          nxt = model_pc + rv_fe_pkg::INSN_BYTES;
        end
        exp_pcs.pc      = model_pc;
        exp_pcs.pc_next = nxt;
        exp_meta        = '{pend, btb_hit_i, btb_taken_i, btb_is_return_i, ras_valid_i,
                            btb_tgt_i, ras_tgt_i};
        model_pc        = nxt;
        model_valid     = 1'b1;
      end
    end
  end

  // All sources idle and fetch always ready
  task automatic clear_inputs();
    redirect_i      = 1'b0;
    redirect_tgt_i  = '0;
    late_pred_i     = 1'b0;
    late_pred_tgt_i = '0;
    btb_hit_i       = 1'b0;
    btb_taken_i     = 1'b0;
    btb_tgt_i       = '0;
    btb_is_return_i = 1'b0;
    ras_valid_i     = 1'b0;
    ras_tgt_i       = '0;
    ready_i         = 1'b1;
  endtask

  // Waits for n more transfers with optional random fetch stalls
  task automatic run_xfers(input int n, input bit rand_ready);
    int target;
    target = xfer_count + n;
    while (xfer_count < target) begin
      @(negedge clk);
      if (rand_ready) begin
        ready_i = ($urandom % 2) == 1;
      end
    end
    ready_i = 1'b1;
  endtask

  task automatic test_sequential();
    cur_test = "sequential";
    clear_inputs();
    run_xfers(8, 1'b0);
  endtask

  // Redirect must beat both late and early predictions
  task automatic test_redirect();
    cur_test        = "redirect";
    redirect_i      = 1'b1;
    redirect_tgt_i  = 32'h0000_4000;
    late_pred_i     = 1'b1;
    late_pred_tgt_i = 32'h0000_5000;
    btb_hit_i       = 1'b1;
    btb_taken_i     = 1'b1;
    btb_tgt_i       = 32'h0000_6000;
    run_xfers(6, 1'b0);
  endtask

  // Decode prediction must beat a BTB taken hit held at the same time
  task automatic test_late_vs_early();
    cur_test = "late_vs_early";
    clear_inputs();
    late_pred_i     = 1'b1;
    late_pred_tgt_i = 32'h0000_2200;
    btb_hit_i       = 1'b1;
    btb_taken_i     = 1'b1;
    btb_tgt_i       = 32'h0000_3300;
    run_xfers(4, 1'b0);
    // BTB hit alone
    late_pred_i = 1'b0;
    run_xfers(4, 1'b0);
  endtask

  // RAS target wins over the BTB target on a return hit
  task automatic test_ras_return();
    cur_test = "ras_return";
    clear_inputs();
    btb_hit_i       = 1'b1;
    btb_is_return_i = 1'b1;
    btb_taken_i     = 1'b1;
    btb_tgt_i       = 32'h0000_8800;
    ras_valid_i     = 1'b1;
    ras_tgt_i       = 32'h0000_7700;
    run_xfers(4, 1'b0);
    ras_valid_i = 1'b0;
    btb_taken_i = 1'b0;
    run_xfers(4, 1'b0);
  endtask

  task automatic test_backpressure();
    cur_test = "backpressure";
    clear_inputs();
    run_xfers(8, 1'b1);
    // Taken branch while fetch stalls
    btb_hit_i   = 1'b1;
    btb_taken_i = 1'b1;
    btb_tgt_i   = 32'h0000_9000;
    run_xfers(8, 1'b1);
  endtask

  initial begin : main
    void'($urandom(32'h0120b38a));
    clear_inputs();
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    test_sequential();
    test_redirect();
    test_late_vs_early();
    test_ras_return();
    test_backpressure();
    repeat (2) @(negedge clk);
    $display("Transfers %0d, checks %0d, errors %0d", xfer_count, checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Timeout, only %0d of %0d transfers arrived", xfer_count, TOTAL_XFERS);
    $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
verilog/rv_fe_pkg.sv
verilog/rv_pc_sel_if.sv
verilog/rv_pipe_ctrl.sv
verilog/rv_pipe_reg.sv
verilog/rv_pc_arb.sv
verilog/rv_stage_pc.sv
verilog/rv_fetch_front.sv
verification/rv_fetch_front_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the fetch front end testbench with Verilator
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module rv_fetch_front_tb -f files.f &&
  ./obj_dir/Vrv_fetch_front_tb > sim.log 2>&1 &&
  ! grep -q "Test FAILED" sim.log &&
  cat sim.log ||
  { cat sim.log 2>/dev/null; echo "Simulation run failed"; exit 1; }
